/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cart_loader
FLIST     = flist.f

BUILD   = obj_dir
SIM     = $(BUILD)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FLIST)) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* cart_loader_top.sv */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module cart_loader_top import loader_pkg::*, cart_pkg::*; (
	input  logic                                  clk_sys,
	input  logic                                  RESET,
	input  logic                                  dl_active,
	input  logic [7:0]                            dl_index,
	input  logic [`LDR_ADDR_W-1:0]                dl_addr,
	input  logic [`LDR_DATA_W-1:0]                dl_data,
	input  logic                                  dl_wr,
	input  logic [2:0]                            header_mode,
	input  logic [1:0]                            region_sel,
	input  logic [1:0]                            wram_init,
	input  logic                                  code_credit,
	output logic [7:0]                            rom_type,
	output logic [23:0]                           rom_mask,
	output logic [23:0]                           ram_mask,
	output logic                                  pal,
	output logic                                  cart_ready,
	output logic                                  clearing,
	output logic [`LDR_WRAM_ADDR_W-1:0]           fill_addr,
	output logic [7:0]                            fill_data,
	output logic                                  fill_we,
	output logic                                  code_valid,
	output logic [`LDR_CODE_WORDS*`LDR_DATA_W-1:0] code_word,
	output logic                                  codes_clear
);

	dl_if        dl ();
	cart_info_t  info;
	cheat_code_t code_asm;
	cheat_code_t code_out;
	logic        code_done;

	// ======================================================================
	// Input side
	// ======================================================================

	download_decoder u_decoder (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_wr     (dl_wr),
		.dl        (dl.src)
	);

	// ======================================================================
	// Header and cheat processing
	// ======================================================================

	rom_header_parser u_parser (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl          (dl.dst),
		.header_mode (header_mode_t'(header_mode)),
		.region_sel  (region_sel),
		.info        (info),
		.cart_ready  (cart_ready)
	);

	cheat_code_assembler u_assembler (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl          (dl.dst),
		.code        (code_asm),
		.code_done   (code_done),
		.codes_clear (codes_clear)
	);

	// ======================================================================
	// Output side
	// ======================================================================

	// Sweep starts with every cartridge download
	wram_clear_engine u_clear (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.start     (dl.cart_start),
		.wram_init (wram_init_t'(wram_init)),
		.clearing  (clearing),
		.fill_addr (fill_addr),
		.fill_data (fill_data),
		.fill_we   (fill_we)
	);

	cheat_code_queue u_queue (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.code        (code_asm),
		.code_done   (code_done),
		.code_valid  (code_valid),
		.code_word   (code_out),
		.code_credit (code_credit)
	);

	assign rom_type  = info.rom_type;
	assign rom_mask  = info.rom_mask;
	assign ram_mask  = info.ram_mask;
	assign pal       = info.pal;
	assign code_word = code_out;

endmodule

/* cart_pkg.sv */
`include "loader_cfg.svh"

package cart_pkg;

	import loader_pkg::*;

	// ======================================================================
	// Cartridge result as seen by the core
	// ======================================================================

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} cart_info_t;

	// ======================================================================
	// Cheat code
	// ======================================================================

	// Field view, each field big endian as delivered by the host tool
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Assembler fills words, consumer decodes fields
	typedef union packed {
		dl_word_t [`LDR_CODE_WORDS-1:0] words;
		cheat_fields_t                  f;
	} cheat_code_t;

	// ======================================================================
	// Power-on work RAM content
	// ======================================================================

	typedef enum logic [1:0] {
		WRAM_9966 = 2'd0,
		WRAM_00FF = 2'd1,
		WRAM_55   = 2'd2,
		WRAM_FF   = 2'd3
	} wram_init_t;

endpackage

/* cheat_code_assembler.sv */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module cheat_code_assembler import loader_pkg::*, cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	dl_if.dst           dl,
	output cheat_code_t code,
	output logic        code_done,
	output logic        codes_clear
);

	// Byte offset of the last word in a code
	localparam logic [3:0] LAST_OFF = 4'((`LDR_CODE_WORDS - 1) * 2);

	logic       code_beat;
	logic [2:0] slot;

	assign code_beat = dl.beat && (dl.kind == DL_CODE);

	// Low word of each field comes first, fields from flags down to replace
	// Offset 0 lands in word 6, offset 2 in word 7, offset 14 in word 1
	assign slot = {~dl.addr[3], ~dl.addr[2], dl.addr[1]};

	always_ff @(posedge clk_sys) begin
		if (code_beat)
			code.words[slot] <= dl.data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_done   <= 1'b0;
			codes_clear <= 1'b0;
		end else begin
			code_done   <= code_beat && (dl.addr[3:0] == LAST_OFF);
			// New cartridge or a fresh cheat list drops the old codes
			codes_clear <= dl.cart_start || (code_beat && dl.addr == '0);
		end
	end

endmodule

/* cheat_code_queue.sv */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module cheat_code_queue import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  cheat_code_t code,
	input  logic        code_done,
	output logic        code_valid,
	output cheat_code_t code_word,
	input  logic        code_credit
);

	localparam int DEPTH   = `LDR_QUEUE_DEPTH;
	localparam int CREDITS = `LDR_CREDITS;
	localparam int PTR_W   = $clog2(DEPTH);
	localparam int CNT_W   = $clog2(DEPTH + 1);
	localparam int CRD_W   = $clog2(CREDITS + 1);

	cheat_code_t      mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic             full;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));

	// Send whenever a code waits and the consumer has room
	assign pop        = (count != '0) && (credits != '0);
	assign push       = code_done && (!full || pop);
	assign code_valid = pop;
	assign code_word  = mem[rd_ptr];

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= code;
	end

	// ======================================================================
	// Pointers and credit count
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= CRD_W'(CREDITS);
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			credits <= credits + CRD_W'(code_credit) - CRD_W'(pop);
		end
	end

	// More codes than entries while the consumer holds back
	a_no_overflow: assert property (@(posedge clk_sys) disable iff (RESET)
		code_done |-> !full || pop);

	// A returned credit must belong to a code that was sent
	a_credit_bound: assert property (@(posedge clk_sys) disable iff (RESET)
		code_credit && !pop |-> credits < CRD_W'(CREDITS));

endmodule

/* dl_if.sv */
`timescale 1ns/1ps

interface dl_if import loader_pkg::*; ();

	// One word per beat, no stall
	logic     beat;
	dl_kind_t kind;
	dl_addr_t addr;
	dl_word_t data;

	// Cartridge download edges
	logic     cart_start;
	logic     cart_end;

	modport src (
		output beat, kind, addr, data, cart_start, cart_end
	);

	modport dst (
		input beat, kind, addr, data, cart_start, cart_end
	);

endinterface

/* download_decoder.sv */
`timescale 1ns/1ps

module download_decoder import loader_pkg::*; (
	input  logic     clk_sys,
	input  logic     RESET,
	input  logic     dl_active,
	input  logic [7:0] dl_index,
	input  dl_addr_t dl_addr,
	input  dl_word_t dl_data,
	input  logic     dl_wr,
	dl_if.src        dl
);

	logic     cart_now;
	logic     cart_q;
	dl_kind_t kind_next;

	assign cart_now = dl_active && (dl_index == 8'd0);

	// Index 0 is the cartridge image, 255 the cheat list
	always_comb begin
		kind_next = DL_NONE;
		if (dl_active) begin
			if (dl_index == 8'd0)
				kind_next = DL_CART;
			else if (dl_index == 8'hFF)
				kind_next = DL_CODE;
		end
	end

	// Word and address ride along with the beat
	always_ff @(posedge clk_sys) begin
		dl.addr <= dl_addr;
		dl.data <= dl_data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl.beat       <= 1'b0;
			dl.kind       <= DL_NONE;
			cart_q        <= 1'b0;
			dl.cart_start <= 1'b0;
			dl.cart_end   <= 1'b0;
		end else begin
			dl.beat       <= dl_wr && dl_active;
			dl.kind       <= kind_next;
			cart_q        <= cart_now;
			// Edge detect on the cartridge download window
			dl.cart_start <= cart_now && !cart_q;
			dl.cart_end   <= !cart_now && cart_q;
		end
	end

endmodule

/* flist.f */
+incdir+.
loader_pkg.sv
cart_pkg.sv
dl_if.sv
download_decoder.sv
rom_header_parser.sv
cheat_code_assembler.sv
wram_clear_engine.sv
cheat_code_queue.sv
cart_loader_top.sv
tb_cart_loader.sv

/* loader_cfg.svh */
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// ==========================================================================
// Download stream geometry
// ==========================================================================

`define LDR_ADDR_W 25
`define LDR_DATA_W 16

// Size word of each header layout, 512-byte copier header included
// RAM size lives in the word two bytes above
`define LDR_HDR_LOROM   'h81D6
`define LDR_HDR_HIROM   'h101D6
`define LDR_HDR_EXHIROM 'h4101D6

// ROM size code for auto mode with an empty first byte
`define LDR_DEFAULT_ROM_SIZE 12

// ==========================================================================
// Work RAM and cheat path
// ==========================================================================

`define LDR_WRAM_ADDR_W 17

`define LDR_CODE_WORDS 8

`define LDR_QUEUE_DEPTH 4

// Slots on the consumer side
`define LDR_CREDITS 2

`endif

/* loader_pkg.sv */
`include "loader_cfg.svh"

package loader_pkg;

	// What the host is currently sending
	typedef enum logic [7:0] {
		DL_NONE = 8'd0,
		DL_CART = 8'd1,
		DL_CODE = 8'd2
	} dl_kind_t;

	typedef logic [`LDR_DATA_W-1:0] dl_word_t;

	typedef logic [`LDR_ADDR_W-1:0] dl_addr_t;

	// Header layout chosen from the menu
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

endpackage

/* rom_header_parser.sv */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module rom_header_parser import loader_pkg::*, cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         RESET,
	dl_if.dst            dl,
	input  header_mode_t header_mode,
	input  logic [1:0]   region_sel,
	output cart_info_t   info,
	output logic         cart_ready
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic [7:0]  rom_type;
	logic        region;
	logic        busy;
	logic        hdr_beat;
	logic        layout;
	dl_addr_t    size_addr;
	dl_addr_t    ram_addr;
	logic [23:0] rom_mask_calc;
	logic [23:0] ram_mask_calc;

	assign hdr_beat = dl.beat && (dl.kind == DL_CART);

	// Where the size bytes sit for the selected layout
	always_comb begin
		layout    = 1'b1;
		size_addr = '0;
		case (header_mode)
			HDR_LOROM:   size_addr = dl_addr_t'(`LDR_HDR_LOROM);
			HDR_HIROM:   size_addr = dl_addr_t'(`LDR_HDR_HIROM);
			HDR_EXHIROM: size_addr = dl_addr_t'(`LDR_HDR_EXHIROM);
			default:     layout = 1'b0;
		endcase
	end

	assign ram_addr = size_addr + dl_addr_t'(2);

	// Size codes count in 1 KB steps
	assign rom_mask_calc = (24'd1024 << rom_size) - 24'd1;
	assign ram_mask_calc = (ram_size != 4'd0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;

	// ======================================================================
	// Header capture
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (hdr_beat) begin
			if (dl.addr == '0) begin
				rom_size <= 4'(`LDR_DEFAULT_ROM_SIZE);
				ram_size <= 4'd0;
				// Auto mode trusts the first byte when it is set
				if (header_mode == HDR_AUTO && dl.data[7:0] != 8'd0)
					{ram_size, rom_size} <= dl.data[7:0];
				case (header_mode)
					HDR_NONE, HDR_LOROM: rom_type <= 8'd0;
					HDR_HIROM:           rom_type <= 8'd1;
					HDR_EXHIROM:         rom_type <= 8'd2;
					default:             rom_type <= dl.data[15:8];
				endcase
			end
			if (layout && dl.addr == size_addr)
				rom_size <= dl.data[11:8];
			if (layout && dl.addr == ram_addr)
				ram_size <= dl.data[3:0];
		end
	end

	// ======================================================================
	// Result and region
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			busy       <= 1'b0;
			region     <= 1'b0;
			cart_ready <= 1'b0;
			info       <= '0;
		end else begin
			cart_ready <= dl.cart_end;
			if (dl.cart_start)
				busy <= 1'b1;
			else if (dl.cart_end)
				busy <= 1'b0;
			if (hdr_beat && dl.addr == dl_addr_t'(2))
				region <= dl.data[8];
			if (dl.cart_end) begin
				info.rom_type <= rom_type;
				info.rom_mask <= rom_mask_calc;
				info.ram_mask <= ram_mask_calc;
			end
			// Menu overrides the header unless left on auto
			if (!busy && !dl.cart_start)
				info.pal <= (region_sel == 2'd0) ? region : region_sel[1];
		end
	end

endmodule

/* tb_cart_loader.sv */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module tb_cart_loader import loader_pkg::*, cart_pkg::*; ();

	localparam int CASES      = 6;
	localparam int FILL_WORDS = 6;
	localparam int SWEEP      = 1 << `LDR_WRAM_ADDR_W;
	localparam int DL_LEN     = FILL_WORDS + 8;
	localparam int MAX_CODES  = 16;
	localparam int MAX_CYCLES = 8 + CASES * (SWEEP + DL_LEN + 32) + 2000;

	// One cartridge download and the header result it must give
	typedef struct packed {
		header_mode_t mode;
		dl_word_t     w0;
		dl_word_t     w2;
		dl_word_t     size_w;
		dl_word_t     ram_w;
		logic [1:0]   region_sel;
		wram_init_t   init;
		cart_info_t   exp;
	} cart_case_t;

	// Idle region changes as {region_sel, pal}
	localparam logic [2:0] REGION_STEPS [4] = '{
		{2'd1, 1'b0}, {2'd0, 1'b1}, {2'd3, 1'b1}, {2'd1, 1'b0}
	};

	logic                                   clk_sys     = 1'b0;
	logic                                   RESET       = 1'b1;
	logic                                   dl_active   = 1'b0;
	logic [7:0]                             dl_index    = 8'd0;
	dl_addr_t                               dl_addr     = '0;
	dl_word_t                               dl_data     = '0;
	logic                                   dl_wr       = 1'b0;
	logic [2:0]                             header_mode = 3'd0;
	logic [1:0]                             region_sel  = 2'd0;
	logic [1:0]                             wram_init   = 2'd0;
	logic                                   code_credit = 1'b0;
	logic [7:0]                             rom_type;
	logic [23:0]                            rom_mask;
	logic [23:0]                            ram_mask;
	logic                                   pal;
	logic                                   cart_ready;
	logic                                   clearing;
	logic [`LDR_WRAM_ADDR_W-1:0]            fill_addr;
	logic [7:0]                             fill_data;
	logic                                   fill_we;
	logic                                   code_valid;
	logic [`LDR_CODE_WORDS*`LDR_DATA_W-1:0] code_word;
	logic                                   codes_clear;

	cart_case_t  cases [CASES];
	cheat_code_t exp_codes [MAX_CODES];
	int          exp_written     = 0;
	int          exp_read        = 0;
	int          received        = 0;
	int          owed            = 0;
	int          clear_pulses    = 0;
	int          expected_clears = 0;
	int          sweeps_done     = 0;
	int          sweep_next      = 0;
	int          sweep_writes    = 0;
	int          cycles          = 0;
	logic        clearing_seen   = 1'b0;
	logic        credit_auto     = 1'b1;
	logic [15:0] lfsr_state      = 16'd36218;

	cart_loader_top i_dut (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_wr       (dl_wr),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.wram_init   (wram_init),
		.code_credit (code_credit),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal),
		.cart_ready  (cart_ready),
		.clearing    (clearing),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.fill_we     (fill_we),
		.code_valid  (code_valid),
		.code_word   (code_word),
		.codes_clear (codes_clear)
	);

	always #20 clk_sys = ~clk_sys;

	// ==========================================================================
	// Reporting and compare helpers
	// ==========================================================================

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_info(input string name, input cart_info_t act, input cart_info_t exp);
		if (act !== exp)
			fail_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_code(input cheat_code_t act, input cheat_code_t exp);
		if (act.f.flags !== exp.f.flags)
			fail_run($sformatf("mismatch at %0t: code flags expected %h got %h",
				$time, exp.f.flags, act.f.flags));
		if (act.f.address !== exp.f.address)
			fail_run($sformatf("mismatch at %0t: code address expected %h got %h",
				$time, exp.f.address, act.f.address));
		if (act.f.compare !== exp.f.compare)
			fail_run($sformatf("mismatch at %0t: code compare expected %h got %h",
				$time, exp.f.compare, act.f.compare));
		if (act.f.replace !== exp.f.replace)
			fail_run($sformatf("mismatch at %0t: code replace expected %h got %h",
				$time, exp.f.replace, act.f.replace));
	endtask

	task automatic check_fill(input string name, input logic [7:0] act, input logic [7:0] exp);
		if (act !== exp)
			fail_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_count(input string name, input int act, input int exp);
		if (act != exp)
			fail_run($sformatf("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act));
	endtask

	function automatic cart_info_t current_info();
		return '{rom_type, rom_mask, ram_mask, pal};
	endfunction

	// Fill byte for one work RAM address
	function automatic logic [7:0] pattern_byte(input wram_init_t sel,
		input logic [`LDR_WRAM_ADDR_W-1:0] a);
		case (sel)
			WRAM_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			WRAM_00FF: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			WRAM_55:   return 8'h55;
			default:   return 8'hFF;
		endcase
	endfunction

	// Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_random_word(output dl_word_t w);
		int i;
		w = '0;
		for (i = 0; i < `LDR_DATA_W; i++) begin
			w = {w[`LDR_DATA_W-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// ==========================================================================
	// Stimulus
	// ==========================================================================

	task automatic load_cases();
		cases[0] = '{HDR_AUTO, 16'h2A00, 16'h0100, 16'h0900, 16'h0003, 2'd0, WRAM_9966,
			'{8'h2A, 24'h3FFFFF, 24'h000000, 1'b1}};
		cases[1] = '{HDR_AUTO, 16'h153B, 16'h0000, 16'h0800, 16'h0002, 2'd2, WRAM_00FF,
			'{8'h15, 24'h1FFFFF, 24'h001FFF, 1'b1}};
		cases[2] = '{HDR_NONE, 16'h77C4, 16'h0100, 16'h0B00, 16'h0007, 2'd1, WRAM_55,
			'{8'h00, 24'h3FFFFF, 24'h000000, 1'b0}};
		cases[3] = '{HDR_LOROM, 16'h1234, 16'h0000, 16'h0A20, 16'h0005, 2'd0, WRAM_FF,
			'{8'h00, 24'h0FFFFF, 24'h007FFF, 1'b0}};
		cases[4] = '{HDR_HIROM, 16'h0000, 16'h0100, 16'h0C31, 16'h00F1, 2'd3, WRAM_9966,
			'{8'h01, 24'h3FFFFF, 24'h0007FF, 1'b1}};
		cases[5] = '{HDR_EXHIROM, 16'hFFFF, 16'h0100, 16'h0D00, 16'h0000, 2'd0, WRAM_00FF,
			'{8'h02, 24'h7FFFFF, 24'h000000, 1'b1}};
	endtask

	task automatic write_word(input dl_addr_t a, input dl_word_t d);
		@(negedge clk_sys);
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
	endtask

	// Layouts without a size word still get one at the LoROM offset
	task automatic send_cart(input int r);
		dl_addr_t size_a;
		dl_word_t w;
		int       i;
		@(negedge clk_sys);
		dl_index  = 8'd0;
		dl_active = 1'b1;
		dl_wr     = 1'b0;
		write_word('0, cases[r].w0);
		write_word(dl_addr_t'(2), cases[r].w2);
		for (i = 0; i < FILL_WORDS; i++) begin
			take_random_word(w);
			write_word(dl_addr_t'(4 + 2 * i), w);
		end
		case (cases[r].mode)
			HDR_HIROM:   size_a = dl_addr_t'(`LDR_HDR_HIROM);
			HDR_EXHIROM: size_a = dl_addr_t'(`LDR_HDR_EXHIROM);
			default:     size_a = dl_addr_t'(`LDR_HDR_LOROM);
		endcase
		write_word(size_a, cases[r].size_w);
		write_word(size_a + dl_addr_t'(2), cases[r].ram_w);
		@(negedge clk_sys);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
	endtask

	// Words at offset 2i, low half of each field first
	task automatic send_codes(input int first, input int n);
		dl_word_t    w [`LDR_CODE_WORDS];
		cheat_code_t e;
		int          k;
		int          i;
		@(negedge clk_sys);
		dl_index  = 8'hFF;
		dl_active = 1'b1;
		dl_wr     = 1'b0;
		for (k = 0; k < n; k++) begin
			for (i = 0; i < `LDR_CODE_WORDS; i++) begin
				take_random_word(w[i]);
				write_word(dl_addr_t'(16 * (first + k) + 2 * i), w[i]);
			end
			e.f.flags   = {w[1], w[0]};
			e.f.address = {w[3], w[2]};
			e.f.compare = {w[5], w[4]};
			e.f.replace = {w[7], w[6]};
			exp_codes[exp_written] = e;
			exp_written++;
		end
		@(negedge clk_sys);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
	endtask

	// ==========================================================================
	// Monitors
	// ==========================================================================

	// Work RAM sweep order and content
	always @(negedge clk_sys) begin
		if (!RESET) begin
			if (fill_we) begin
				if (!clearing)
					fail_run("fill write seen while clearing is low");
				if (!clearing_seen) begin
					sweep_next   = 0;
					sweep_writes = 0;
				end
				check_count("fill_addr", int'(fill_addr), sweep_next);
				check_fill("fill_data", fill_data,
					pattern_byte(wram_init_t'(wram_init), fill_addr));
				sweep_next++;
				sweep_writes++;
			end
			if (clearing_seen && !clearing) begin
				check_count("writes in one sweep", sweep_writes, SWEEP);
				sweeps_done++;
			end
			clearing_seen = clearing;
		end
	end

	// Consumer side of the cheat queue, one credit back per cycle
	always @(negedge clk_sys) begin
		code_credit = 1'b0;
		if (!RESET) begin
			if (credit_auto && owed > 0) begin
				code_credit = 1'b1;
				owed--;
			end
			if (code_valid) begin
				if (exp_read >= exp_written)
					fail_run("code_valid raised with no cheat code written");
				check_code(cheat_code_t'(code_word), exp_codes[exp_read]);
				exp_read++;
				received++;
				owed++;
			end
			if (codes_clear)
				clear_pulses++;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > MAX_CYCLES)
			fail_run($sformatf("run went past %0d cycles without finishing", MAX_CYCLES));
	end

	// ==========================================================================
	// Test sequence
	// ==========================================================================

	initial begin
		int         r;
		int         k;
		int         base;
		cart_info_t exp;
		load_cases();
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		if (cart_ready || clearing || fill_we || code_valid || codes_clear)
			fail_run("outputs are not idle after reset");

		for (r = 0; r < CASES; r++) begin
			@(negedge clk_sys);
			header_mode = cases[r].mode;
			region_sel  = cases[r].region_sel;
			wram_init   = cases[r].init;
			send_cart(r);
			expected_clears++;
			while (!cart_ready)
				@(negedge clk_sys);
			// pal follows once the download window has closed
			repeat (2) @(negedge clk_sys);
			check_info($sformatf("cart_info row %0d", r), current_info(), cases[r].exp);
			while (clearing)
				@(negedge clk_sys);
			@(negedge clk_sys);
			check_count("completed sweeps", sweeps_done, r + 1);
			check_count("codes_clear pulses", clear_pulses, expected_clears);
		end

		// Menu region against the last header region
		exp = cases[CASES-1].exp;
		for (k = 0; k < 4; k++) begin
			@(negedge clk_sys);
			region_sel = REGION_STEPS[k][2:1];
			repeat (2) @(negedge clk_sys);
			exp.pal = REGION_STEPS[k][0];
			check_info("cart_info after region_sel change", current_info(), exp);
		end

		// Codes with the consumer returning credits
		credit_auto = 1'b1;
		send_codes(0, 3);
		expected_clears++;
		while (received < 3)
			@(negedge clk_sys);
		while (owed != 0)
			@(negedge clk_sys);
		check_count("codes_clear pulses", clear_pulses, expected_clears);

		// Credits held back, list continues above address 0
		credit_auto = 1'b0;
		base = received;
		send_codes(1, 4);
		repeat (40) @(negedge clk_sys);
		check_count("codes sent without credit return", received - base, `LDR_CREDITS);
		credit_auto = 1'b1;
		while (received < base + 4)
			@(negedge clk_sys);
		repeat (4) @(negedge clk_sys);
		check_count("codes_clear pulses", clear_pulses, expected_clears);

		if (exp_read == exp_written && sweeps_done == CASES) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("codes or sweeps missing at the end of the run");
			$display("tests failed");
			$fatal(1, "run ended with missing results");
		end
	end

endmodule

/* wram_clear_engine.sv */
`timescale 1ns/1ps
`include "loader_cfg.svh"

module wram_clear_engine import cart_pkg::*; #(
	parameter int ADDR_W = `LDR_WRAM_ADDR_W
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              start,
	input  wram_init_t        wram_init,
	output logic              clearing,
	output logic [ADDR_W-1:0] fill_addr,
	output logic [7:0]        fill_data,
	output logic              fill_we
);

	logic [ADDR_W-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing <= 1'b0;
			cnt      <= '0;
		end else if (start) begin
			clearing <= 1'b1;
			cnt      <= '0;
		end else if (clearing) begin
			cnt <= cnt + 1'b1;
			// Last address written this cycle
			if (&cnt)
				clearing <= 1'b0;
		end
	end

	assign fill_addr = cnt;
	assign fill_we   = clearing;

	// Patterns of the different console revisions
	always_comb begin
		case (wram_init)
			WRAM_9966: fill_data = (cnt[8] ^ cnt[2]) ? 8'h66 : 8'h99;
			WRAM_00FF: fill_data = (cnt[9] ^ cnt[0]) ? 8'hFF : 8'h00;
			WRAM_55:   fill_data = 8'h55;
			default:   fill_data = 8'hFF;
		endcase
	end

endmodule
